/* design/displayPkg.sv */
package displayPkg;

	// Pixel coordinate, holds up to 255
	typedef logic [7:0] coordT;

	// Image ROM address, 160 x 120 needs 15 bits
	typedef logic [14:0] romAddrT;

	// Default VGA screen in pixels
	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;

	// Square sprite side
	localparam int SPRITE_SIZE = 40;

	// Clocks per tick, 4 Hz on a 50 MHz clock
	localparam int TICK_CYCLES = 12_500_000;

	// Dog origin, sprite fills the right quarter
	function automatic coordT DOG_X(input int screenW);
		return coordT'(screenW - screenW / 4);
	endfunction

	// Cat origin, one eighth in from the left
	function automatic coordT CAT_X(input int screenW);
		return coordT'(screenW / 8);
	endfunction

	// Both sprites centred on the vertical axis
	function automatic coordT SPRITE_Y(input int screenH, input int spriteSize);
		return coordT'((screenH - spriteSize) / 2);
	endfunction

endpackage

/* design/scenePkg.sv */
package scenePkg;

	// Image select, picks the ROM outside the design
	typedef enum logic [2:0] {
		imgTitle1 = 3'd0,
		imgTitle2 = 3'd1,
		imgTitle3 = 3'd2,
		imgDog    = 3'd3,
		imgCat    = 3'd4,
		imgBlank  = 3'd5
	} imageT;

	// Controller states
	typedef enum logic [3:0] {
		// Full screen title raster
		sTitleDraw = 4'd0,
		// Hold title until next tick
		sTitleWait = 4'd1,
		// Sprites of the scene
		sDog       = 4'd2,
		sCat       = 4'd3,
		// Hold scene until next tick
		sSceneWait = 4'd4,
		// Clear screen before redraw
		sBlank     = 4'd5
	} sceneStateT;

	// Rectangle to draw, origin plus extent
	typedef struct packed {
		imageT             image;
		displayPkg::coordT x;
		displayPkg::coordT y;
		displayPkg::coordT width;
		displayPkg::coordT height;
	} drawCmdT;

	// One plotted pixel
	typedef struct packed {
		displayPkg::coordT   x;
		displayPkg::coordT   y;
		imageT               image;
		displayPkg::romAddrT romAddr;
	} pixelT;

endpackage

/* design/tickDivider.sv */
`timescale 1ns/10ps

module tickDivider #(
	parameter int TICK_CYCLES = displayPkg::TICK_CYCLES
) (
	input  logic clk,
	input  logic reset,
	input  logic tickRestart,
	output logic tick
);

	// Counter wide enough for the whole period
	localparam int COUNT_W = $clog2(TICK_CYCLES + 1);

	typedef logic [COUNT_W-1:0] countT;

	// Zero is reached TICK_CYCLES clocks after a reload
	localparam countT RELOAD = countT'(TICK_CYCLES - 1);

	countT count;

	// One cycle pulse at terminal count
	assign tick = (count == '0);

	always_ff @(posedge clk) begin
		// Restart lines the period up with the end of a frame
		if (reset || tickRestart || tick) begin
			count <= RELOAD;
		end else begin
			count <= count - 1'b1;
		end
	end

endmodule

/* design/rasterWalker.sv */
`timescale 1ns/10ps

module rasterWalker (
	input  logic              clk,
	input  logic              reset,
	input  scenePkg::drawCmdT cmd,
	input  logic              drawReq,
	output logic              drawAck,
	output scenePkg::pixelT   pixel,
	output logic              plot
);

	// Command held for the rectangle in flight
	scenePkg::drawCmdT cmdReg;

	// Position inside the rectangle
	displayPkg::coordT xOff;
	displayPkg::coordT yOff;

	// ROM address, one step per pixel
	displayPkg::romAddrT addr;

	logic busy;
	logic start;
	logic rowEnd;
	logic lastPixel;

	// New request only once the previous ack has gone low
	assign start = drawReq && !drawAck && !busy;

	// End of row and end of rectangle
	assign rowEnd = (xOff == cmdReg.width - 1'b1);
	assign lastPixel = rowEnd && (yOff == cmdReg.height - 1'b1);

	// Handshake and busy flag
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			drawAck <= 1'b0;
		end else begin
			if (start) begin
				busy <= 1'b1;
			end else if (busy && lastPixel) begin
				// Ack follows the last pixel by one cycle
				busy <= 1'b0;
				drawAck <= 1'b1;
			end
			// Return to idle once request is released
			if (drawAck && !drawReq) begin
				drawAck <= 1'b0;
			end
		end
	end

	// Raster position and address
	always_ff @(posedge clk) begin
		if (start) begin
			cmdReg <= cmd;
			xOff <= '0;
			yOff <= '0;
			addr <= '0;
		end else if (busy) begin
			addr <= addr + 1'b1;
			// Row major walk
			if (rowEnd) begin
				xOff <= '0;
				yOff <= yOff + 1'b1;
			end else begin
				xOff <= xOff + 1'b1;
			end
		end
	end

	// Every busy cycle is a pixel
	assign plot = busy;

	// Screen coordinate is origin plus offset
	always_comb begin
		pixel.x = cmdReg.x + xOff;
		pixel.y = cmdReg.y + yOff;
		pixel.image = cmdReg.image;
		pixel.romAddr = addr;
	end

endmodule

/* design/sceneController.sv */
`timescale 1ns/10ps

module sceneController #(
	parameter int SCREEN_W    = displayPkg::SCREEN_W,
	parameter int SCREEN_H    = displayPkg::SCREEN_H,
	parameter int SPRITE_SIZE = displayPkg::SPRITE_SIZE
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              userCont,
	input  logic              tick,
	output logic              tickRestart,
	output scenePkg::drawCmdT cmd,
	output logic              drawReq,
	input  logic              drawAck
);

	// Full screen extent
	localparam displayPkg::coordT FULL_W = displayPkg::coordT'(SCREEN_W);
	localparam displayPkg::coordT FULL_H = displayPkg::coordT'(SCREEN_H);

	// Sprite extent and origins
	localparam displayPkg::coordT SPRITE_SIDE = displayPkg::coordT'(SPRITE_SIZE);
	localparam displayPkg::coordT DOG_ORIGIN_X = displayPkg::DOG_X(SCREEN_W);
	localparam displayPkg::coordT CAT_ORIGIN_X = displayPkg::CAT_X(SCREEN_W);
	localparam displayPkg::coordT SPRITE_ORIGIN_Y = displayPkg::SPRITE_Y(SCREEN_H, SPRITE_SIZE);

	scenePkg::sceneStateT state;

	// Title currently shown
	scenePkg::imageT titleImg;
	scenePkg::imageT nextTitle;

	logic pressLatch;
	logic pressSeen;
	logic drawState;
	logic frameDone;

	// States that hold a draw command
	assign drawState = (state == scenePkg::sTitleDraw) || (state == scenePkg::sDog) ||
		(state == scenePkg::sCat) || (state == scenePkg::sBlank);

	// Ack seen while still requesting
	assign frameDone = drawReq && drawAck;

	// Press on the closing cycle counts too
	assign pressSeen = pressLatch || userCont;

	// Title order 1, 2, 3, 1
	always_comb begin
		case (titleImg)
			scenePkg::imgTitle1: nextTitle = scenePkg::imgTitle2;
			scenePkg::imgTitle2: nextTitle = scenePkg::imgTitle3;
			default: nextTitle = scenePkg::imgTitle1;
		endcase
	end

	// Tick period starts when a frame that waits ends
	assign tickRestart = frameDone &&
		(((state == scenePkg::sTitleDraw) && !pressSeen) || (state == scenePkg::sCat));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= scenePkg::sTitleDraw;
			titleImg <= scenePkg::imgTitle1;
			pressLatch <= 1'b0;
			drawReq <= 1'b0;
		end else begin
			// Press only matters during a title raster
			if ((state == scenePkg::sTitleDraw) && userCont) begin
				pressLatch <= 1'b1;
			end
			// Four phase request, wait for ack low before raising
			if (drawState && !drawReq && !drawAck) begin
				drawReq <= 1'b1;
			end else if (frameDone) begin
				drawReq <= 1'b0;
			end
			case (state)
				scenePkg::sTitleDraw: begin
					if (frameDone && pressSeen) begin
						// Straight to the scene, no tick
						state <= scenePkg::sDog;
						pressLatch <= 1'b0;
					end else if (frameDone) begin
						state <= scenePkg::sTitleWait;
					end
				end
				scenePkg::sTitleWait: begin
					if (tick) begin
						titleImg <= nextTitle;
						state <= scenePkg::sTitleDraw;
					end
				end
				scenePkg::sDog: begin
					if (frameDone) state <= scenePkg::sCat;
				end
				scenePkg::sCat: begin
					if (frameDone) state <= scenePkg::sSceneWait;
				end
				scenePkg::sSceneWait: begin
					if (tick) state <= scenePkg::sBlank;
				end
				scenePkg::sBlank: begin
					// Cleared, redraw both sprites
					if (frameDone) state <= scenePkg::sDog;
				end
				default: state <= scenePkg::sTitleDraw;
			endcase
		end
	end

	// Command per state, full screen unless a sprite
	always_comb begin
		cmd.image = titleImg;
		cmd.x = '0;
		cmd.y = '0;
		cmd.width = FULL_W;
		cmd.height = FULL_H;
		case (state)
			scenePkg::sDog: begin
				cmd.image = scenePkg::imgDog;
				cmd.x = DOG_ORIGIN_X;
				cmd.y = SPRITE_ORIGIN_Y;
				cmd.width = SPRITE_SIDE;
				cmd.height = SPRITE_SIDE;
			end
			scenePkg::sCat: begin
				cmd.image = scenePkg::imgCat;
				cmd.x = CAT_ORIGIN_X;
				cmd.y = SPRITE_ORIGIN_Y;
				cmd.width = SPRITE_SIDE;
				cmd.height = SPRITE_SIDE;
			end
			scenePkg::sBlank: cmd.image = scenePkg::imgBlank;
			default: cmd.image = titleImg;
		endcase
	end

endmodule

/* design/gameDisplay.sv */
`timescale 1ns/10ps

module gameDisplay #(
	parameter int SCREEN_W    = displayPkg::SCREEN_W,
	parameter int SCREEN_H    = displayPkg::SCREEN_H,
	parameter int SPRITE_SIZE = displayPkg::SPRITE_SIZE,
	parameter int TICK_CYCLES = displayPkg::TICK_CYCLES
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            userCont,
	output scenePkg::pixelT pixel,
	output logic            plot
);

	// Draw command handshake
	scenePkg::drawCmdT cmd;
	logic drawReq;
	logic drawAck;

	// Slow pacing
	logic tick;
	logic tickRestart;

	// Picks what to draw and when
	sceneController #(
		.SCREEN_W   (SCREEN_W),
		.SCREEN_H   (SCREEN_H),
		.SPRITE_SIZE(SPRITE_SIZE)
	) i_sceneController (
		.clk        (clk),
		.reset      (reset),
		.userCont   (userCont),
		.tick       (tick),
		.tickRestart(tickRestart),
		.cmd        (cmd),
		.drawReq    (drawReq),
		.drawAck    (drawAck)
	);

	// Turns commands into pixels
	rasterWalker i_rasterWalker (
		.clk    (clk),
		.reset  (reset),
		.cmd    (cmd),
		.drawReq(drawReq),
		.drawAck(drawAck),
		.pixel  (pixel),
		.plot   (plot)
	);

	tickDivider #(
		.TICK_CYCLES(TICK_CYCLES)
	) i_tickDivider (
		.clk        (clk),
		.reset      (reset),
		.tickRestart(tickRestart),
		.tick       (tick)
	);

endmodule

/* sim/pixelChecker.sv */
`timescale 1ns/10ps

module pixelChecker #(
	parameter int SCREEN_W    = 16,
	parameter int SCREEN_H    = 12,
	parameter int SPRITE_SIZE = 4,
	parameter int TICK_CYCLES = 200
) (
	input  logic            clk,
	input  logic            plot,
	input  scenePkg::pixelT pixel,
	input  logic            caseStart,
	input  int              titleFrames,
	input  int              sceneReps,
	output logic            caseDone,
	output int              framesSeen,
	output int              valueErrors,
	output int              missingFrames
);

	// Dog in the right quarter, cat one eighth in, both centred vertically
	localparam int DOG_X    = 3 * SCREEN_W / 4;
	localparam int CAT_X    = SCREEN_W / 8;
	localparam int SPRITE_Y = SCREEN_H / 2 - SPRITE_SIZE / 2;

	// Handshake teardown allowance around each frame
	localparam int GAP_SLACK = 8;
	// Idle clocks before a frame counts as lost
	localparam int WAIT_LIMIT = TICK_CYCLES + 64;

	task automatic compareField(input string name, input int expectedV, input int actualV);
		if (expectedV != actualV) begin
			valueErrors++;
			$display("Fail %0t: %s expected %0d, actual %0d", $time, name, expectedV, actualV);
		end
	endtask

	// Title order 1, 2, 3 and round again
	function automatic scenePkg::imageT titleOf(input int k);
		case (k % 3)
			0: return scenePkg::imgTitle1;
			1: return scenePkg::imgTitle2;
			default: return scenePkg::imgTitle3;
		endcase
	endfunction

	// Idle gap then one rectangle sampled on falling edges
	task automatic checkFrame(input scenePkg::imageT img, input int ox, input int oy,
		input int w, input int h, input int minGap, input int maxGap, output bit ok);
		int gap;
		int i;
		gap = 0;
		ok = 1'b0;
		@(negedge clk);
		while (!plot && gap < WAIT_LIMIT) begin
			gap++;
			@(negedge clk);
		end
		if (!plot) begin
			missingFrames++;
			$display("%0t: the %s frame never arrived", $time, img.name());
			return;
		end
		// Tick paced frames must not come early
		if (gap < minGap) begin
			valueErrors++;
			$display("Fail %0t: idle gap before %s expected at least %0d, actual %0d",
				$time, img.name(), minGap, gap);
		end
		if (gap > maxGap) begin
			valueErrors++;
			$display("Fail %0t: idle gap before %s expected at most %0d, actual %0d",
				$time, img.name(), maxGap, gap);
		end
		// Row major walk with addresses from zero
		for (i = 0; i < w * h; i++) begin
			if (i > 0) @(negedge clk);
			compareField("plot", 1, int'(plot));
			compareField("pixel.x", ox + i % w, int'(pixel.x));
			compareField("pixel.y", oy + i / w, int'(pixel.y));
			compareField("pixel.image", int'(img), int'(pixel.image));
			compareField("pixel.romAddr", i, int'(pixel.romAddr));
		end
		framesSeen++;
		ok = 1'b1;
	endtask

	// Dog then cat straight after the previous frame
	task automatic checkSprites(output bit ok);
		checkFrame(scenePkg::imgDog, DOG_X, SPRITE_Y, SPRITE_SIZE, SPRITE_SIZE,
			0, 2 * GAP_SLACK, ok);
		if (ok) begin
			checkFrame(scenePkg::imgCat, CAT_X, SPRITE_Y, SPRITE_SIZE, SPRITE_SIZE,
				0, 2 * GAP_SLACK, ok);
		end
	endtask

	initial begin
		bit ok;
		int k;
		int r;
		int minGap;
		caseDone = 1'b0;
		framesSeen = 0;
		valueErrors = 0;
		missingFrames = 0;
		forever begin
			wait (caseStart);
			framesSeen = 0;
			ok = 1'b1;
			// Titles up to and including the pressed one
			for (k = 0; k <= titleFrames && ok; k++) begin
				if (k == 0) begin
					minGap = 0;
				end else begin
					minGap = TICK_CYCLES - GAP_SLACK;
				end
				checkFrame(titleOf(k), 0, 0, SCREEN_W, SCREEN_H, minGap, WAIT_LIMIT, ok);
			end
			// Press skips the tick
			if (ok) checkSprites(ok);
			// Each repeat clears the screen on the tick first
			for (r = 0; r < sceneReps && ok; r++) begin
				checkFrame(scenePkg::imgBlank, 0, 0, SCREEN_W, SCREEN_H,
					TICK_CYCLES - GAP_SLACK, WAIT_LIMIT, ok);
				if (ok) checkSprites(ok);
			end
			caseDone = 1'b1;
			wait (!caseStart);
			caseDone = 1'b0;
		end
	end

endmodule

/* sim/gameDisplay_asserts.sv */
`timescale 1ns/10ps

module gameDisplay_asserts #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
) (
	input logic            clk,
	input logic            reset,
	input logic            drawReq,
	input logic            drawAck,
	input scenePkg::pixelT pixel,
	input logic            plot
);

	int failCount;

	initial failCount = 0;

	// Ack only rises against a live request
	ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(drawAck) |-> drawReq)
		else begin
			failCount++;
			$error("drawAck rose while drawReq was low");
		end

	// Request held until acknowledged
	reqHeld: assert property (@(posedge clk) disable iff (reset)
		(drawReq && !drawAck) |=> drawReq)
		else begin
			failCount++;
			$error("drawReq dropped before drawAck");
		end

	// Every plotted pixel lands on the screen
	plotOnScreen: assert property (@(posedge clk) disable iff (reset)
		plot |-> (int'(pixel.x) < SCREEN_W && int'(pixel.y) < SCREEN_H))
		else begin
			failCount++;
			$error("pixel plotted outside the screen");
		end

endmodule

// Walker handshake and pixel output as seen from the top level
bind gameDisplay gameDisplay_asserts #(
	.SCREEN_W(SCREEN_W),
	.SCREEN_H(SCREEN_H)
) i_asserts (
	.clk    (clk),
	.reset  (reset),
	.drawReq(drawReq),
	.drawAck(drawAck),
	.pixel  (pixel),
	.plot   (plot)
);

/* sim/gameDisplayTb.sv */
`timescale 1ns/10ps

module gameDisplayTb;

	// Small screen so a frame is a few hundred clocks
	localparam int SCREEN_W    = 16;
	localparam int SCREEN_H    = 12;
	localparam int SPRITE_SIZE = 4;
	localparam int TICK_CYCLES = 200;

	localparam int CLK_PERIOD = 8;
	localparam int MAX_CASES  = 16;

	logic            clk;
	logic            reset;
	logic            userCont;
	scenePkg::pixelT pixel;
	logic            plot;

	// Checker handshake and its results
	logic caseStart;
	logic caseDone;
	int   titleFrames;
	int   sceneReps;
	int   framesSeen;
	int   valueErrors;
	int   missingFrames;

	// Three bytes per case, ff ends the table
	logic [7:0] caseMem [0:3*MAX_CASES-1];
	int         caseCount;
	int         countErrors;
	bit [31:0]  rngState;
	longint     limitNs;
	bit         limitReady;

	gameDisplay #(
		.SCREEN_W   (SCREEN_W),
		.SCREEN_H   (SCREEN_H),
		.SPRITE_SIZE(SPRITE_SIZE),
		.TICK_CYCLES(TICK_CYCLES)
	) i_gameDisplay (
		.clk     (clk),
		.reset   (reset),
		.userCont(userCont),
		.pixel   (pixel),
		.plot    (plot)
	);

	pixelChecker #(
		.SCREEN_W   (SCREEN_W),
		.SCREEN_H   (SCREEN_H),
		.SPRITE_SIZE(SPRITE_SIZE),
		.TICK_CYCLES(TICK_CYCLES)
	) i_pixelChecker (
		.clk          (clk),
		.plot         (plot),
		.pixel        (pixel),
		.caseStart    (caseStart),
		.titleFrames  (titleFrames),
		.sceneReps    (sceneReps),
		.caseDone     (caseDone),
		.framesSeen   (framesSeen),
		.valueErrors  (valueErrors),
		.missingFrames(missingFrames)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Xorshift step for the press position
	function automatic bit [31:0] nextRandom(input bit [31:0] s);
		bit [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Upper bound on one case in clocks, frames plus tick waits
	function automatic longint caseCycles(input int titles, input int reps, input int frames);
		longint drawn;
		longint waited;
		drawn = longint'(frames) * longint'(SCREEN_W * SCREEN_H + 16);
		waited = longint'(titles + reps) * longint'(TICK_CYCLES + 16);
		return drawn + waited + 8;
	endfunction

	// One cycle press a few pixels into the chosen title frame
	task automatic pressDuring(input int frameIdx, input int pixelIdx);
		int   seen;
		logic prevPlot;
		seen = 0;
		prevPlot = 1'b0;
		// Count frame starts on the falling edge
		while (seen <= frameIdx) begin
			@(negedge clk);
			if (plot && !prevPlot) seen++;
			prevPlot = plot;
		end
		repeat (pixelIdx) @(negedge clk);
		@(posedge clk);
		#1 userCont = 1'b1;
		@(posedge clk);
		#1 userCont = 1'b0;
	endtask

	task automatic runCase(input int idx);
		int pressAt;
		int expectedFrames;
		titleFrames = int'(caseMem[3*idx]);
		sceneReps = int'(caseMem[3*idx+1]);
		expectedFrames = int'(caseMem[3*idx+2]);
		// Middle half of the frame, well away from both edges
		rngState = nextRandom(rngState);
		pressAt = SCREEN_W * SCREEN_H / 4 + int'(rngState % (SCREEN_W * SCREEN_H / 2));
		@(posedge clk);
		#1;
		reset = 1'b1;
		caseStart = 1'b1;
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		pressDuring(titleFrames, pressAt);
		wait (caseDone);
		if (framesSeen != expectedFrames) begin
			countErrors++;
			$display("Fail %0t: framesSeen expected %0d, actual %0d",
				$time, expectedFrames, framesSeen);
		end
		caseStart = 1'b0;
		wait (!caseDone);
	endtask

	initial begin
		int i;
		int total;
		reset = 1'b1;
		userCont = 1'b0;
		caseStart = 1'b0;
		titleFrames = 0;
		sceneReps = 0;
		countErrors = 0;
		rngState = 32'h6991df8c;
		limitReady = 1'b0;
		$readmemh("sim/sceneCases.txt", caseMem);
		caseCount = 0;
		while (caseCount < MAX_CASES && caseMem[3*caseCount] != 8'hff) caseCount++;
		// Startup margin, then every case twice over
		limitNs = 1000;
		for (i = 0; i < caseCount; i++) begin
			limitNs += caseCycles(int'(caseMem[3*i]), int'(caseMem[3*i+1]),
				int'(caseMem[3*i+2]));
		end
		limitNs = limitNs * 2 * CLK_PERIOD;
		limitReady = 1'b1;
		if (caseCount == 0) begin
			countErrors++;
			$display("No cases could be read from sim/sceneCases.txt");
		end
		for (i = 0; i < caseCount; i++) begin
			runCase(i);
		end
		@(posedge clk);
		total = valueErrors + missingFrames + countErrors + i_gameDisplay.i_asserts.failCount;
		$display("Errors: pixel values %0d, missing frames %0d, frame counts %0d, assertions %0d",
			valueErrors, missingFrames, countErrors, i_gameDisplay.i_asserts.failCount);
		if (total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Hung DUT or lost frame ends the run here
	initial begin
		wait (limitReady);
		#(limitNs);
		$display("Watchdog: run did not finish within %0d ns", limitNs);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* sim/sceneCases.txt */
// Columns in hex: title frames before the pressed one, scene repeats, total frames checked
// Total frames = titles + 1 + 2 + 3 * repeats, a line of ff ends the table
00 01 06
01 00 04
02 02 0b
03 01 09
04 00 07
ff ff ff

/* gameDisplay.f */
design/displayPkg.sv
design/scenePkg.sv
design/tickDivider.sv
design/rasterWalker.sv
design/sceneController.sv
design/gameDisplay.sv
sim/pixelChecker.sv
sim/gameDisplay_asserts.sv
sim/gameDisplayTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= gameDisplayTb
FILELIST  ?= gameDisplay.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from the pass line in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
